// File: rv_consts.svh
/*
  core-wide sizes for the RV32I pipeline
  widths below assume a 32-bit datapath and 32 registers
*/
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// data and pc width
`define RV_XLEN 32

// architectural register count and its index width
`define RV_NUM_REGS 32
`define RV_REG_ADDR_W 5

// pc value out of reset
`define RV_PC_RESET 32'h0000_0000

// fall-through step, no compressed instructions
`define RV_INSN_BYTES 4

`endif

// File: rv_pkg.sv
/*
  shared types for the RV32I core
  alu_op_e keeps illegal as its last value, decode relies on that ordering
*/
`default_nettype none

package rv_pkg;

  // major opcodes of the supported instruction groups
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // one value per operation after funct3/funct7 decode
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_BEQ,
    ALU_BNE,
    ALU_BLT,
    ALU_BGE,
    ALU_BLTU,
    ALU_BGEU,
    ALU_JAL,
    ALU_JALR,
    ALU_LUI,
    ALU_AUIPC,
    ALU_ECALL,
    ALU_ILLEGAL
  } alu_op_e;

endpackage

`default_nettype wire

// File: rv_stage_if.sv
/*
  stage-to-stage links of the core
  all strobes are single cycle with no ready, the sink must take them at once
*/
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

// decoded instruction, decode to execute
interface decode_if;
  logic                      valid;
  rv_pkg::alu_op_e           op;
  logic [`RV_REG_ADDR_W-1:0] rd;
  logic [`RV_REG_ADDR_W-1:0] rs1;
  logic [`RV_REG_ADDR_W-1:0] rs2;
  logic                      use_imm;
  logic [`RV_XLEN-1:0]       imm;
  // already low when rd is x0
  logic                      we;

  modport source (output valid, op, rd, rs1, rs2, use_imm, imm, we);
  modport sink   (input valid, op, rd, rs1, rs2, use_imm, imm, we);
endinterface

// register file read, data comes back in the same cycle
interface reg_read_if;
  logic [`RV_REG_ADDR_W-1:0] rs1;
  logic [`RV_REG_ADDR_W-1:0] rs2;
  logic [`RV_XLEN-1:0]       rs1_data;
  logic [`RV_XLEN-1:0]       rs2_data;

  modport requester (output rs1, rs2, input rs1_data, rs2_data);
  modport responder (input rs1, rs2, output rs1_data, rs2_data);
endinterface

// executed instruction, execute to result
interface result_if;
  logic                      valid;
  logic [`RV_XLEN-1:0]       pc;
  logic [`RV_XLEN-1:0]       next_pc;
  logic [`RV_REG_ADDR_W-1:0] rd;
  logic                      we;
  logic [`RV_XLEN-1:0]       data;

  modport source (output valid, pc, next_pc, rd, we, data);
  modport sink   (input valid, pc, next_pc, rd, we, data);
endinterface

`default_nettype wire

// File: rv_decode.sv
/*
  instruction decode, one cycle from the sampling edge to dec.valid
  unknown encodings decode to the illegal op with no register write
*/
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module rv_decode (
  input  logic                clk,
  input  logic                rst,
  input  logic                insn_valid,
  input  logic [`RV_XLEN-1:0] insn,
  decode_if.source            dec
);

  logic                insn_vld_q;
  logic [`RV_XLEN-1:0] insn_q;

  rv_pkg::opcode_e     opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i, imm_b, imm_j, imm_u;

  rv_pkg::alu_op_e     op_d;
  logic                use_imm_d;
  logic [`RV_XLEN-1:0] imm_d;
  logic                wr_d;

  // shared funct3 map of the reg-imm and reg-reg groups
  function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic [6:0] f7,
                                               input logic is_reg);
    logic f7_ok;
    f7_ok = !is_reg || (f7 == 7'b0000000);
    arith_op = rv_pkg::ALU_ILLEGAL;
    case (f3)
      3'b000: begin
        if (is_reg && f7 == 7'b0100000) begin
          arith_op = rv_pkg::ALU_SUB;
        end else if (f7_ok) begin
          arith_op = rv_pkg::ALU_ADD;
        end
      end
      3'b001: if (f7 == 7'b0000000) arith_op = rv_pkg::ALU_SLL;
      3'b010: if (f7_ok) arith_op = rv_pkg::ALU_SLT;
      3'b011: if (f7_ok) arith_op = rv_pkg::ALU_SLTU;
      3'b100: if (f7_ok) arith_op = rv_pkg::ALU_XOR;
      3'b101: begin
        if (f7 == 7'b0000000) begin
          arith_op = rv_pkg::ALU_SRL;
        end else if (f7 == 7'b0100000) begin
          arith_op = rv_pkg::ALU_SRA;
        end
      end
      3'b110: if (f7_ok) arith_op = rv_pkg::ALU_OR;
      default: if (f7_ok) arith_op = rv_pkg::ALU_AND;
    endcase
  endfunction

  // capture the strobed instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      insn_vld_q <= 1'b0;
    end else begin
      insn_vld_q <= insn_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (insn_valid) begin
      insn_q <= insn;
    end
  end

  assign opcode = rv_pkg::opcode_e'(insn_q[6:0]);
  assign funct3 = insn_q[14:12];
  assign funct7 = insn_q[31:25];

  assign imm_i = {{20{insn_q[31]}}, insn_q[31:20]};
  assign imm_b = {{19{insn_q[31]}}, insn_q[31], insn_q[7], insn_q[30:25], insn_q[11:8], 1'b0};
  assign imm_j = {{11{insn_q[31]}}, insn_q[31], insn_q[19:12], insn_q[20], insn_q[30:21], 1'b0};
  assign imm_u = {insn_q[31:12], 12'd0};

  always_comb begin
    op_d      = rv_pkg::ALU_ILLEGAL;
    use_imm_d = 1'b0;
    imm_d     = imm_i;
    case (opcode)
      rv_pkg::OPC_LUI: begin
        op_d  = rv_pkg::ALU_LUI;
        imm_d = imm_u;
      end
      rv_pkg::OPC_AUIPC: begin
        op_d  = rv_pkg::ALU_AUIPC;
        imm_d = imm_u;
      end
      rv_pkg::OPC_JAL: begin
        op_d  = rv_pkg::ALU_JAL;
        imm_d = imm_j;
      end
      rv_pkg::OPC_JALR: if (funct3 == 3'b000) op_d = rv_pkg::ALU_JALR;
      rv_pkg::OPC_BRANCH: begin
        imm_d = imm_b;
        case (funct3)
          3'b000:  op_d = rv_pkg::ALU_BEQ;
          3'b001:  op_d = rv_pkg::ALU_BNE;
          3'b100:  op_d = rv_pkg::ALU_BLT;
          3'b101:  op_d = rv_pkg::ALU_BGE;
          3'b110:  op_d = rv_pkg::ALU_BLTU;
          3'b111:  op_d = rv_pkg::ALU_BGEU;
          default: op_d = rv_pkg::ALU_ILLEGAL;
        endcase
      end
      rv_pkg::OPC_OP_IMM: begin
        op_d      = arith_op(funct3, funct7, 1'b0);
        use_imm_d = 1'b1;
      end
      rv_pkg::OPC_OP: op_d = arith_op(funct3, funct7, 1'b1);
      rv_pkg::OPC_SYSTEM: if (insn_q[31:7] == 25'd0) op_d = rv_pkg::ALU_ECALL;
      default: op_d = rv_pkg::ALU_ILLEGAL;
    endcase
  end

  // branches, ecall and illegal leave the register file alone
  assign wr_d = !(op_d inside {rv_pkg::ALU_BEQ, rv_pkg::ALU_BNE, rv_pkg::ALU_BLT,
                               rv_pkg::ALU_BGE, rv_pkg::ALU_BLTU, rv_pkg::ALU_BGEU,
                               rv_pkg::ALU_ECALL, rv_pkg::ALU_ILLEGAL});

  always_ff @(posedge clk) begin
    if (rst) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= insn_vld_q;
    end
  end

  always_ff @(posedge clk) begin
    dec.op      <= op_d;
    dec.rd      <= insn_q[11:7];
    dec.rs1     <= insn_q[19:15];
    dec.rs2     <= insn_q[24:20];
    dec.use_imm <= use_imm_d;
    dec.imm     <= imm_d;
    dec.we      <= wr_d && (insn_q[11:7] != '0);
  end

  // a strobed op is always one of the defined operations
  a_op_defined: assert property (@(posedge clk) disable iff (rst)
    dec.valid |-> !$isunknown(dec.op) && (dec.op <= rv_pkg::ALU_ILLEGAL));

endmodule

`default_nettype wire

// File: rv_execute.sv
/*
  execute stage, owns the pc and the sticky halt
  operands bypass from the retiring result, older results come from the register file
  jump and branch targets are forced to word alignment
*/
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module rv_execute (
  input  logic          clk,
  input  logic          rst,
  decode_if.sink        dec,
  reg_read_if.requester rd_port,
  result_if.source      res,
  output logic          halt
);

  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] rs1_val, rs2_val, opb;
  logic [`RV_XLEN-1:0] alu_res, link, next_pc;
  logic                byp1, byp2;
  logic                taken;
  logic                accept;

  assign rd_port.rs1 = dec.rs1;
  assign rd_port.rs2 = dec.rs2;

  // the retiring write lands at the end of this cycle, so take it from our own register
  assign byp1 = res.valid && res.we && (res.rd == dec.rs1);
  assign byp2 = res.valid && res.we && (res.rd == dec.rs2);

  assign rs1_val = byp1 ? res.data : rd_port.rs1_data;
  assign rs2_val = byp2 ? res.data : rd_port.rs2_data;
  assign opb     = dec.use_imm ? dec.imm : rs2_val;
  assign link    = pc + `RV_XLEN'(`RV_INSN_BYTES);

  always_comb begin
    case (dec.op)
      rv_pkg::ALU_ADD:   alu_res = rs1_val + opb;
      rv_pkg::ALU_SUB:   alu_res = rs1_val - opb;
      rv_pkg::ALU_SLL:   alu_res = rs1_val << opb[4:0];
      rv_pkg::ALU_SLT:   alu_res = `RV_XLEN'($signed(rs1_val) < $signed(opb));
      rv_pkg::ALU_SLTU:  alu_res = `RV_XLEN'(rs1_val < opb);
      rv_pkg::ALU_XOR:   alu_res = rs1_val ^ opb;
      rv_pkg::ALU_SRL:   alu_res = rs1_val >> opb[4:0];
      rv_pkg::ALU_SRA:   alu_res = $signed(rs1_val) >>> opb[4:0];
      rv_pkg::ALU_OR:    alu_res = rs1_val | opb;
      rv_pkg::ALU_AND:   alu_res = rs1_val & opb;
      rv_pkg::ALU_JAL,
      rv_pkg::ALU_JALR:  alu_res = link;
      rv_pkg::ALU_LUI:   alu_res = dec.imm;
      rv_pkg::ALU_AUIPC: alu_res = pc + dec.imm;
      default:           alu_res = '0;
    endcase
  end

  always_comb begin
    case (dec.op)
      rv_pkg::ALU_BEQ:  taken = (rs1_val == rs2_val);
      rv_pkg::ALU_BNE:  taken = (rs1_val != rs2_val);
      rv_pkg::ALU_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
      rv_pkg::ALU_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      rv_pkg::ALU_BLTU: taken = (rs1_val < rs2_val);
      rv_pkg::ALU_BGEU: taken = (rs1_val >= rs2_val);
      default:          taken = 1'b0;
    endcase
  end

  // illegal and ecall fall through like any other non-jump
  always_comb begin
    next_pc = link;
    if (dec.op == rv_pkg::ALU_JALR) begin
      next_pc = (rs1_val + dec.imm) & ~`RV_XLEN'(3);
    end else if (dec.op == rv_pkg::ALU_JAL || taken) begin
      next_pc = (pc + dec.imm) & ~`RV_XLEN'(3);
    end
  end

  // nothing past an ecall is executed
  assign accept = dec.valid && !halt;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= `RV_PC_RESET;
      halt      <= 1'b0;
      res.valid <= 1'b0;
    end else begin
      res.valid <= accept;
      if (accept) begin
        pc   <= next_pc;
        halt <= (dec.op == rv_pkg::ALU_ECALL);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res.pc      <= pc;
      res.next_pc <= next_pc;
      res.rd      <= dec.rd;
      res.we      <= dec.we;
      res.data    <= alu_res;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rv_result.sv
/*
  register file and retire ports
  reads are combinational, a retiring write is seen from the next cycle on
*/
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module rv_result (
  input  logic                      clk,
  input  logic                      rst,
  reg_read_if.responder             rd_port,
  result_if.sink                    res,
  output logic                      retire_valid,
  output logic [`RV_XLEN-1:0]       retire_pc,
  output logic [`RV_XLEN-1:0]       retire_next_pc,
  output logic [`RV_XLEN-1:0]       retire_data,
  output logic [`RV_REG_ADDR_W-1:0] retire_rd,
  output logic                      retire_we
);

  logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (res.valid && res.we) begin
      regs[res.rd] <= res.data;
    end
  end

  // x0 reads as zero
  assign rd_port.rs1_data = (rd_port.rs1 == '0) ? '0 : regs[rd_port.rs1];
  assign rd_port.rs2_data = (rd_port.rs2 == '0) ? '0 : regs[rd_port.rs2];

  assign retire_valid   = res.valid;
  assign retire_pc      = res.pc;
  assign retire_next_pc = res.next_pc;
  assign retire_rd      = res.rd;
  assign retire_we      = res.we;
  assign retire_data    = res.data;

  // decode drops the write enable for rd x0
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
    (res.valid && res.we) |-> (res.rd != '0));

endmodule

`default_nettype wire

// File: riscv_core.sv
/*
  RV32I integer core, no memories, instructions arrive on insn_valid/insn
  retire_valid follows the sampling edge by two cycles, halt stays high until reset
*/
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module riscv_core (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      insn_valid,
  input  logic [`RV_XLEN-1:0]       insn,
  output logic                      retire_valid,
  output logic [`RV_XLEN-1:0]       retire_pc,
  output logic [`RV_XLEN-1:0]       retire_next_pc,
  output logic [`RV_REG_ADDR_W-1:0] retire_rd,
  output logic                      retire_we,
  output logic [`RV_XLEN-1:0]       retire_data,
  output logic                      halt
);

  decode_if   dec_if ();
  reg_read_if rr_if ();
  result_if   res_if ();

  rv_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .insn_valid (insn_valid),
    .insn       (insn),
    .dec        (dec_if.source)
  );

  rv_execute u_execute (
    .clk     (clk),
    .rst     (rst),
    .dec     (dec_if.sink),
    .rd_port (rr_if.requester),
    .res     (res_if.source),
    .halt    (halt)
  );

  rv_result u_result (
    .clk            (clk),
    .rst            (rst),
    .rd_port        (rr_if.responder),
    .res            (res_if.sink),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_next_pc (retire_next_pc),
    .retire_data    (retire_data),
    .retire_rd      (retire_rd),
    .retire_we      (retire_we)
  );

endmodule

`default_nettype wire

// File: tb_riscv_core.sv
/*
  testbench for riscv_core, stimulus and expected retire values come from rv_vectors.txt
  NUM_VECS must match the number of lines in that file
  a vector whose pc column is ffffffff is sent after the ecall and must not retire
*/
`timescale 1ns/100ps
`default_nettype none
`include "rv_consts.svh"

module tb_riscv_core;

  localparam int NUM_VECS = 36;
  localparam int VEC_WORDS = 6;
  localparam int MAX_GAP = 3;
  localparam int TIMEOUT_CYCLES = NUM_VECS * (MAX_GAP + 3) + 20;
  localparam int IDLE_CHECK_CYCLES = 4;
  localparam int HALT_WATCH_CYCLES = 8;
  localparam logic [15:0] LFSR_SEED = 16'd55383;
  localparam logic [31:0] NO_RETIRE = 32'hffff_ffff;
  localparam logic [31:0] ECALL_WORD = 32'h0000_0073;
  localparam logic [6:0] OPCODE_OP = 7'b0110011;

  logic                      clk;
  logic                      rst;
  logic                      insn_valid;
  logic [`RV_XLEN-1:0]       insn;
  logic                      retire_valid;
  logic [`RV_XLEN-1:0]       retire_pc;
  logic [`RV_XLEN-1:0]       retire_next_pc;
  logic [`RV_REG_ADDR_W-1:0] retire_rd;
  logic                      retire_we;
  logic [`RV_XLEN-1:0]       retire_data;
  logic                      halt;

  // six words per vector: insn, pc, next_pc, rd, we, data
  logic [31:0] vec_mem [NUM_VECS*VEC_WORDS];
  int          exp_q[$];
  int          expected_total = 0;
  int          retired_count = 0;
  int          error_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;
  logic [15:0] lfsr_state;

  riscv_core dut_i (
    .clk            (clk),
    .rst            (rst),
    .insn_valid     (insn_valid),
    .insn           (insn),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_next_pc (retire_next_pc),
    .retire_rd      (retire_rd),
    .retire_we      (retire_we),
    .retire_data    (retire_data),
    .halt           (halt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // two random bits give an idle gap of 0 to 3 cycles
  task automatic draw_gap(output int gap);
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      gap = (gap << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("CHECK FAILED time %0t: %s expected %h got %h", $time, name, exp, got);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count != errs_before) begin
      tests_failed++;
    end
    $display("%s: %s", name, (error_count == errs_before) ? "ok" : "FAILED");
  endtask

  // rd and data only matter when a write is expected
  task automatic check_retire(input int idx);
    int   base;
    int   errs_before;
    logic exp_halt;
    base = idx * VEC_WORDS;
    errs_before = error_count;
    exp_halt = (vec_mem[base] == ECALL_WORD);
    check_value("retire_pc", retire_pc, vec_mem[base+1]);
    check_value("retire_next_pc", retire_next_pc, vec_mem[base+2]);
    check_value("retire_we", {31'd0, retire_we}, vec_mem[base+4]);
    if (vec_mem[base+4][0]) begin
      check_value("retire_rd", {27'd0, retire_rd}, vec_mem[base+3]);
      check_value("retire_data", retire_data, vec_mem[base+5]);
    end
    check_value("halt", {31'd0, halt}, {31'd0, exp_halt});
    report_test($sformatf("vector %0d insn %h", idx, vec_mem[base]), errs_before);
    retired_count++;
  endtask

  // scoreboard, outputs are stable at the falling edge
  // a retire with nothing left to expect is an error of its own
  always @(negedge clk) begin
    if (!rst && retire_valid) begin
      assert (exp_q.size() != 0) else begin
        $display("unexpected retire at time %0t with pc %h, no more retires were expected",
                 $time, retire_pc);
        error_count++;
      end
      if (exp_q.size() != 0) begin
        check_retire(exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, expected retires did not all arrive", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    int          gap;
    int          errs_before;
    logic [31:0] word;
    rst = 1'b1;
    insn_valid = 1'b0;
    insn = '0;
    lfsr_state = LFSR_SEED;
    $readmemh("rv_vectors.txt", vec_mem);
    for (int i = 0; i < NUM_VECS; i++) begin
      if (vec_mem[i*VEC_WORDS+1] != NO_RETIRE) begin
        exp_q.push_back(i);
        expected_total++;
      end
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // nothing retires and halt stays low without a strobe
    errs_before = error_count;
    repeat (IDLE_CHECK_CYCLES) begin
      @(negedge clk);
      check_value("retire_valid", {31'd0, retire_valid}, 32'd0);
      check_value("halt", {31'd0, halt}, 32'd0);
    end
    report_test("reset idle", errs_before);

    // reg-reg ops go back to back so each one hits the bypass
    for (int i = 0; i < NUM_VECS; i++) begin
      word = vec_mem[i*VEC_WORDS];
      if (word[6:0] == OPCODE_OP) begin
        gap = 0;
      end else begin
        draw_gap(gap);
      end
      repeat (gap) begin
        @(negedge clk);
        insn_valid = 1'b0;
      end
      @(negedge clk);
      insn_valid = 1'b1;
      insn = word;
    end
    @(negedge clk);
    insn_valid = 1'b0;

    while (retired_count < expected_total) begin
      @(negedge clk);
    end

    // after the ecall halt holds and later instructions never retire
    errs_before = error_count;
    repeat (HALT_WATCH_CYCLES) begin
      @(negedge clk);
      check_value("halt", {31'd0, halt}, 32'd1);
      check_value("retire_valid", {31'd0, retire_valid}, 32'd0);
    end
    report_test("halt after ecall", errs_before);

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rv_vectors.txt
// columns: insn pc next_pc rd we data, all hex, rd and data only checked when we is 1
// pc ffffffff marks an instruction sent after ecall that must not retire
// lui, auipc and reg-imm operations
123450B7 00000000 00000004 01 1 12345000
00001117 00000004 00000008 02 1 00001004
67808193 00000008 0000000C 03 1 12345678
FFB00213 0000000C 00000010 04 1 FFFFFFFB
FFC22293 00000010 00000014 05 1 00000001
00523313 00000014 00000018 06 1 00000000
FFF1C393 00000018 0000001C 07 1 EDCBA987
0F00E413 0000001C 00000020 08 1 123450F0
0FF1F493 00000020 00000024 09 1 00000078
00419513 00000024 00000028 0A 1 23456780
01C25593 00000028 0000002C 0B 1 0000000F
40125613 0000002C 00000030 0C 1 FFFFFFFD
// dependent reg-reg chain
004186B3 00000030 00000034 0D 1 12345673
40168733 00000034 00000038 0E 1 00000673
00B717B3 00000038 0000003C 0F 1 03398000
00F22833 0000003C 00000040 10 1 00000001
004838B3 00000040 00000044 11 1 00000001
0038C933 00000044 00000048 12 1 12345679
011959B3 00000048 0000004C 13 1 091A2B3C
41325A33 0000004C 00000050 14 1 FFFFFFFF
003A7AB3 00000050 00000054 15 1 12345678
011AEB33 00000054 00000058 16 1 12345679
// branches, then jal and jalr
01518463 00000058 00000060 00 0 00000000
FF5198E3 00000060 00000064 00 0 00000000
00024663 00000064 00000070 00 0 00000000
00025663 00000070 00000074 00 0 00000000
00406863 00000074 00000084 00 0 00000000
00407863 00000084 00000088 00 0 00000000
00800BEF 00000088 00000090 17 1 0000008C
031B8C67 00000090 000000BC 18 1 00000094
// x0 write and read, unknown opcode, ecall
00108013 000000BC 000000C0 00 0 00000000
00306CB3 000000C0 000000C4 19 1 12345678
0000A00B 000000C4 000000C8 00 0 00000000
00000073 000000C8 000000CC 00 0 00000000
00100D13 FFFFFFFF FFFFFFFF 00 0 00000000
00001DB7 FFFFFFFF FFFFFFFF 00 0 00000000

// File: flist.f
+incdir+.
rv_pkg.sv
rv_stage_if.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
riscv_core.sv
tb_riscv_core.sv

// File: run_sim.sh
#!/bin/sh
# build the riscv_core testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -f flist.f --top-module tb_riscv_core -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "^Simulation completed successfully$" &&
echo "run passed" || { echo "run failed"; exit 1; }
